/* logic/pcie_stream_pkg.sv */
package pcie_stream_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int CORE_DATA_W = 64;                    // core beat data, two dws
    localparam int CORE_KEEP_W = CORE_DATA_W / 8;       // one keep bit per byte
    localparam int TLP_DATA_W  = 128;                   // tlp word data, four dws
    localparam int TLP_DW_N    = TLP_DATA_W / 32;       // dws per tlp word
    localparam int BAR_HIT_W   = 7;                     // bar hit sideband from core
    localparam int DW_CNT_W    = 4;                     // upsizer dw count, 0..4

    // --------------------
    // core keep encodings
    // --------------------
    // the core only ever sees whole dws, so two patterns cover every beat
    localparam logic [CORE_KEEP_W-1:0] KEEP_TWO_DW = 8'hff;   // both dws valid
    localparam logic [CORE_KEEP_W-1:0] KEEP_ONE_DW = 8'h0f;   // lower dw only

    // --------------------
    // core side beats
    // --------------------
    // receive beat as handed out by the core, 80 bits
    typedef struct packed {
        logic [CORE_DATA_W-1:0] data;       // dw0 in the low half
        logic [CORE_KEEP_W-1:0] keep;       // upper nibble set means two dws
        logic                   last;       // final beat of the tlp
        logic [BAR_HIT_W-1:0]   bar_hit;    // which bar the tlp decoded to
    } core_rx_beat_t;

    // transmit beat toward the core, 73 bits
    typedef struct packed {
        logic [CORE_DATA_W-1:0] data;       // dw0 in the low half
        logic [CORE_KEEP_W-1:0] keep;       // KEEP_TWO_DW or KEEP_ONE_DW
        logic                   last;       // final beat of the tlp
    } core_tx_beat_t;

    // --------------------
    // 128-bit tlp stream
    // --------------------
    // sideband of one tlp word, 9 bits
    typedef struct packed {
        logic                 first;        // word opens a tlp
        logic                 last;         // word closes a tlp
        logic [BAR_HIT_W-1:0] bar_hit;      // copied from the newest core beat
    } tlp_user_t;

    // one tlp word, 142 bits
    typedef struct packed {
        logic [TLP_DATA_W-1:0] data;        // dw0 in bits 31:0
        logic [TLP_DW_N-1:0]   keepdw;      // one flag per dw, dw0 in bit 0
        logic                  last;        // word closes a tlp
        tlp_user_t             user;        // rx sideband, unused on tx
    } tlp128_beat_t;

endpackage

/* logic/tlp_rx_upsizer.sv */
module tlp_rx_upsizer (
    input  logic                           i_clk_pcie,
    input  logic                           i_rst,
    // core receive beats, always accepted
    input  pcie_stream_pkg::core_rx_beat_t i_core_rx,
    input  logic                           i_core_rx_valid,
    // packed tlp words, each valid for one cycle
    output pcie_stream_pkg::tlp128_beat_t  o_tlp_rx,
    output logic                           o_tlp_rx_valid
);
    import pcie_stream_pkg::*;

    logic [TLP_DATA_W-1:0] word_data;      // dws collected for the open word
    logic [BAR_HIT_W-1:0]  word_bar_hit;   // bar hit of newest beat
    logic [DW_CNT_W-1:0]   dw_cnt;         // dws held in word_data
    logic                  word_last;      // open word got a last beat
    logic                  word_first;     // next word presented opens a tlp
    logic                  word_done;      // word is on the output now
    logic                  beat_two_dw;    // incoming beat carries two dws
    logic [DW_CNT_W-1:0]   base_dw;        // dw slot for the incoming beat
    logic [DW_CNT_W-1:0]   next_cnt;       // count after the incoming beat
    logic [TLP_DW_N-1:0]   word_keepdw;    // per dw valid flags from count

    // --------------------
    // word completion
    // --------------------
    // a word is full at three dws since a beat brings at most two more
    assign word_done   = word_last || (dw_cnt > DW_CNT_W'(2));
    assign beat_two_dw = i_core_rx.keep[CORE_KEEP_W/2];          // upper nibble
    assign base_dw     = word_done ? '0 : dw_cnt;                 // restart after output
    assign next_cnt    = base_dw + (beat_two_dw ? DW_CNT_W'(2) : DW_CNT_W'(1));

    always_comb begin
        for (int i = 0; i < TLP_DW_N; i++) begin
            word_keepdw[i] = (dw_cnt > DW_CNT_W'(i));             // contiguous from dw0
        end
    end

    // --------------------
    // payload capture
    // --------------------
    always_ff @(posedge i_clk_pcie) begin
        if (i_core_rx_valid) begin
            case (base_dw)
                DW_CNT_W'(0): word_data[CORE_DATA_W-1:0] <= i_core_rx.data;
                DW_CNT_W'(1): word_data[CORE_DATA_W/2 +: CORE_DATA_W] <= i_core_rx.data;
                default:      word_data[TLP_DATA_W-1 -: CORE_DATA_W] <= i_core_rx.data;
            endcase
            word_bar_hit <= i_core_rx.bar_hit;                     // newest beat wins
        end
    end

    // --------------------
    // control state
    // --------------------
    always_ff @(posedge i_clk_pcie) begin
        if (i_rst) begin
            dw_cnt     <= '0;
            word_last  <= 1'b0;
            word_first <= 1'b1;                                    // fresh tlp after reset
        end else begin
            if (word_done) begin
                word_first <= word_last;                           // next word opens a tlp
            end
            if (i_core_rx_valid) begin
                dw_cnt    <= next_cnt;                             // beat may start next word
                word_last <= i_core_rx.last;
            end else if (word_done) begin
                dw_cnt    <= '0;                                   // idle after output
                word_last <= 1'b0;
            end
        end
    end

    // --------------------
    // outputs
    // --------------------
    assign o_tlp_rx_valid       = word_done;
    assign o_tlp_rx.data        = word_data;
    assign o_tlp_rx.keepdw      = word_keepdw;
    assign o_tlp_rx.last        = word_last;
    assign o_tlp_rx.user.first  = word_first;
    assign o_tlp_rx.user.last   = word_last;
    assign o_tlp_rx.user.bar_hit = word_bar_hit;

    // a presented word has a dw0-based run of dws, and a short one closes its tlp
    a_keepdw_run: assert property (@(posedge i_clk_pcie) disable iff (i_rst)
        o_tlp_rx_valid |-> (o_tlp_rx.keepdw inside {4'b0001, 4'b0011, 4'b0111, 4'b1111})
                           && (o_tlp_rx.keepdw[TLP_DW_N-1] || o_tlp_rx.last));

    // core only sends a single dw as the tail of a tlp
    a_one_dw_last: assert property (@(posedge i_clk_pcie) disable iff (i_rst)
        (i_core_rx_valid && !beat_two_dw) |-> i_core_rx.last);

endmodule

/* logic/tlp_tx_downsizer.sv */
module tlp_tx_downsizer (
    input  logic                           i_clk_pcie,
    input  logic                           i_rst,
    // 128-bit tlp words from the user side
    input  pcie_stream_pkg::tlp128_beat_t  i_tlp_tx,
    input  logic                           i_tlp_tx_valid,
    output logic                           o_tlp_tx_ready,
    // 64-bit beats toward the core
    output pcie_stream_pkg::core_tx_beat_t o_core_tx,
    output logic                           o_core_tx_valid,
    input  logic                           i_core_tx_ready
);
    import pcie_stream_pkg::*;

    logic                   hi_sel;         // 0 = dws 0-1, 1 = dws 2-3
    logic                   need_hi;        // word has dws in the upper half
    logic                   final_half;     // current half ends the word
    logic                   core_xfer;      // core takes a beat this cycle
    logic                   dw2nd_valid;    // second dw of chosen half present
    logic [CORE_DATA_W-1:0] half_data;      // chosen 64 bits

    // --------------------
    // half selection
    // --------------------
    assign need_hi     = i_tlp_tx.keepdw[2];
    assign final_half  = hi_sel || !need_hi;                  // one beat for short words
    assign core_xfer   = i_tlp_tx_valid && i_core_tx_ready;

    always_comb begin
        if (hi_sel) begin
            half_data   = i_tlp_tx.data[TLP_DATA_W-1 -: CORE_DATA_W];
            dw2nd_valid = i_tlp_tx.keepdw[3];
        end else begin
            half_data   = i_tlp_tx.data[CORE_DATA_W-1:0];
            dw2nd_valid = i_tlp_tx.keepdw[1];
        end
    end

    // --------------------
    // core beat
    // --------------------
    // lower half goes out in the same cycle as the word, no register stage
    assign o_core_tx_valid = i_tlp_tx_valid;
    assign o_core_tx.data  = half_data;
    assign o_core_tx.keep  = dw2nd_valid ? KEEP_TWO_DW : KEEP_ONE_DW;
    assign o_core_tx.last  = i_tlp_tx.last && final_half;   // only on the closing beat

    // word consumed only when its final half is taken by the core
    assign o_tlp_tx_ready  = core_xfer && final_half;

    // --------------------
    // selector state
    // --------------------
    // holds under back-pressure so the upper half is never dropped
    always_ff @(posedge i_clk_pcie) begin
        if (i_rst) begin
            hi_sel <= 1'b0;
        end else if (core_xfer) begin
            hi_sel <= !final_half;                            // step to upper or wrap
        end
    end

    // stalled beat holds, which needs the word source to hold its word too
    a_core_tx_hold: assert property (@(posedge i_clk_pcie) disable iff (i_rst)
        (o_core_tx_valid && !i_core_tx_ready) |=> (o_core_tx_valid && $stable(o_core_tx)));

endmodule

/* logic/pcie_tlp_bridge.sv */
module pcie_tlp_bridge (
    input  logic                           i_clk_pcie,
    input  logic                           i_rst,

    // --------------------
    // receive path
    // --------------------
    input  pcie_stream_pkg::core_rx_beat_t i_core_rx,        // from core, 64-bit
    input  logic                           i_core_rx_valid,
    output pcie_stream_pkg::tlp128_beat_t  o_tlp_rx,         // to user, 128-bit
    output logic                           o_tlp_rx_valid,   // one cycle per word

    // --------------------
    // transmit path
    // --------------------
    input  pcie_stream_pkg::tlp128_beat_t  i_tlp_tx,         // from user, 128-bit
    input  logic                           i_tlp_tx_valid,
    output logic                           o_tlp_tx_ready,
    output pcie_stream_pkg::core_tx_beat_t o_core_tx,        // to core, 64-bit
    output logic                           o_core_tx_valid,
    input  logic                           i_core_tx_ready
);

    // core rx to 128-bit words, one cycle latency, never stalls
    tlp_rx_upsizer tlp_rx_upsizer_inst (
        .i_clk_pcie      (i_clk_pcie),
        .i_rst           (i_rst),
        .i_core_rx       (i_core_rx),
        .i_core_rx_valid (i_core_rx_valid),
        .o_tlp_rx        (o_tlp_rx),
        .o_tlp_rx_valid  (o_tlp_rx_valid)
    );

    // 128-bit words to core tx, lower half with zero latency
    tlp_tx_downsizer tlp_tx_downsizer_inst (
        .i_clk_pcie      (i_clk_pcie),
        .i_rst           (i_rst),
        .i_tlp_tx        (i_tlp_tx),
        .i_tlp_tx_valid  (i_tlp_tx_valid),
        .o_tlp_tx_ready  (o_tlp_tx_ready),
        .o_core_tx       (o_core_tx),
        .o_core_tx_valid (o_core_tx_valid),
        .i_core_tx_ready (i_core_tx_ready)
    );

endmodule

/* testbench/tb_pcie_tlp_bridge.sv */
module tb_pcie_tlp_bridge;
    timeunit 1ns;
    timeprecision 1ps;
    import pcie_stream_pkg::*;

    localparam int RX_N    = 6;       // receive table rows
    localparam int TX_N    = 8;       // transmit table rows
    localparam int MAX_DW  = 8;       // longest rx tlp in the table
    localparam int TIMEOUT = 200;     // cycles per wait loop

    // one receive tlp: length, bar hit, random idles between beats
    typedef struct packed {
        logic [3:0]           len;
        logic [BAR_HIT_W-1:0] bar_hit;
        logic                 gaps;
    } rx_case_t;

    // one transmit word shape
    typedef struct packed {
        logic [TLP_DW_N-1:0] keepdw;
        logic                last;
    } tx_case_t;

    rx_case_t rx_table [RX_N] = '{
        '{4'd1, 7'h01, 1'b0},
        '{4'd3, 7'h02, 1'b1},
        '{4'd4, 7'h04, 1'b0},
        '{4'd5, 7'h08, 1'b1},
        '{4'd8, 7'h10, 1'b1},           // also cut short for the reset case
        '{4'd2, 7'h40, 1'b0}
    };

    tx_case_t tx_table [TX_N] = '{
        '{4'b0001, 1'b1},               // single dw tlp
        '{4'b0011, 1'b1},
        '{4'b0111, 1'b1},               // upper half with one dw
        '{4'b1111, 1'b1},
        '{4'b1111, 1'b0},               // long tlp, middle words
        '{4'b1111, 1'b0},
        '{4'b0111, 1'b1},
        '{4'b0001, 1'b1}
    };

    logic clk_pcie;
    logic rst;
    core_rx_beat_t core_rx;
    logic          core_rx_valid;
    tlp128_beat_t  tlp_rx;
    logic          tlp_rx_valid;
    tlp128_beat_t  tlp_tx;
    logic          tlp_tx_valid;
    logic          tlp_tx_ready;
    core_tx_beat_t core_tx;
    logic          core_tx_valid;
    logic          core_tx_ready;

    int seed = 68363;                   // single seed for data and timing
    int cyc  = 0;                       // rising edges so far
    logic [31:0]  rx_payload [RX_N][MAX_DW+1];   // one spare dw past the end
    tlp128_beat_t tx_words [TX_N];

    tlp128_beat_t  rx_exp_q [$];        // expected rx words
    int            rx_cyc_q [$];        // cycle each word must show up in
    core_tx_beat_t tx_exp_q [$];        // expected core tx beats
    int rx_words_pushed = 0;
    int rx_words_seen   = 0;
    int tx_words_done   = 0;

    // --------------------
    // clock and DUT
    // --------------------
    initial begin
        clk_pcie = 1'b0;
        forever #2 clk_pcie = ~clk_pcie;    // 4 ns period
    end

    always @(posedge clk_pcie) cyc <= cyc + 1;

    pcie_tlp_bridge pcie_tlp_bridge_inst (
        .i_clk_pcie      (clk_pcie),
        .i_rst           (rst),
        .i_core_rx       (core_rx),
        .i_core_rx_valid (core_rx_valid),
        .o_tlp_rx        (tlp_rx),
        .o_tlp_rx_valid  (tlp_rx_valid),
        .i_tlp_tx        (tlp_tx),
        .i_tlp_tx_valid  (tlp_tx_valid),
        .o_tlp_tx_ready  (tlp_tx_ready),
        .o_core_tx       (core_tx),
        .o_core_tx_valid (core_tx_valid),
        .i_core_tx_ready (core_tx_ready)
    );

    // --------------------
    // error handling and compares
    // --------------------
    task automatic abort_run(string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_tlp128(string name, tlp128_beat_t exp_beat, tlp128_beat_t act_beat);
        logic [TLP_DATA_W-1:0] dw_mask;
        for (int i = 0; i < TLP_DW_N; i++) begin
            dw_mask[32*i +: 32] = {32{exp_beat.keepdw[i]}};   // invalid dws are stale
        end
        exp_beat.data = exp_beat.data & dw_mask;
        act_beat.data = act_beat.data & dw_mask;
        if (act_beat !== exp_beat) begin
            abort_run($sformatf("Mismatch %s: expected %h actual %h", name, exp_beat, act_beat));
        end
    endtask

    task automatic compare_core_tx(string name, core_tx_beat_t exp_beat, core_tx_beat_t act_beat);
        if (act_beat !== exp_beat) begin
            abort_run($sformatf("Mismatch %s: expected %h actual %h", name, exp_beat, act_beat));
        end
    endtask

    // --------------------
    // receive side
    // --------------------
    task automatic apply_reset();
        @(negedge clk_pcie);
        rst           = 1'b1;
        core_rx_valid = 1'b0;
        tlp_tx_valid  = 1'b0;
        repeat (8) @(negedge clk_pcie);
        rst = 1'b0;
    endtask

    task automatic drive_rx_idle();
        @(negedge clk_pcie);
        core_rx_valid = 1'b0;
    endtask

    // sends one table tlp, stop_dw cuts it before its tail
    task automatic send_rx_tlp(int idx, bit use_gaps, int stop_dw);
        rx_case_t      c;
        core_rx_beat_t b;
        tlp128_beat_t  w;
        int            n_dw;
        int            pos;
        int            fill;
        int            gap;
        logic          two_dw;
        c    = rx_table[idx];
        n_dw = int'(c.len);
        pos  = 0;
        fill = 0;
        w    = '0;
        w.user.first   = 1'b1;               // opening word of the tlp
        w.user.bar_hit = c.bar_hit;
        while (pos < n_dw && pos < stop_dw) begin
            if (use_gaps) begin
                gap = $random(seed) & 3;
                repeat (gap) begin
                    @(negedge clk_pcie);
                    core_rx_valid = 1'b0;
                end
            end
            two_dw    = (n_dw - pos >= 2);   // odd tail goes out alone
            b.data    = {rx_payload[idx][pos+1], rx_payload[idx][pos]};
            b.keep    = two_dw ? KEEP_TWO_DW : KEEP_ONE_DW;
            b.last    = (n_dw - pos <= 2);
            b.bar_hit = c.bar_hit;
            @(negedge clk_pcie);
            core_rx       = b;
            core_rx_valid = 1'b1;
            w.data[32*fill +: 32] = rx_payload[idx][pos];
            w.keepdw[fill] = 1'b1;
            fill++;
            if (two_dw) begin
                w.data[32*fill +: 32] = rx_payload[idx][pos+1];
                w.keepdw[fill] = 1'b1;
                fill++;
            end
            pos = pos + (two_dw ? 2 : 1);
            if (fill == TLP_DW_N || b.last) begin
                w.last      = b.last;
                w.user.last = b.last;
                rx_exp_q.push_back(w);
                rx_cyc_q.push_back(cyc + 1);  // word follows its closing beat
                rx_words_pushed++;
                w.data        = '0;
                w.keepdw      = '0;
                w.user.first  = 1'b0;
                fill = 0;
            end
        end
    endtask

    task automatic wait_rx_drained();
        int waited;
        waited = 0;
        while (rx_exp_q.size() != 0) begin
            if (waited == TIMEOUT) begin
                abort_run("timeout: o_tlp_rx_valid never delivered the outstanding words");
            end else begin
                @(negedge clk_pcie);
                waited++;
            end
        end
    endtask

    task automatic check_rx_quiet();
        repeat (3) begin
            @(negedge clk_pcie);
            #1;
            if (tlp_rx_valid) begin
                abort_run("o_tlp_rx_valid went high right after reset with no input");
            end
        end
    endtask

    // samples mid-cycle, well clear of both edges
    always @(negedge clk_pcie) begin
        #1;
        if (!rst && tlp_rx_valid) begin
            if (rx_exp_q.size() == 0) begin
                abort_run("o_tlp_rx_valid high with no word expected");
            end else if (cyc != rx_cyc_q[0]) begin
                abort_run($sformatf("Mismatch rx word %0d cycle: expected %0d actual %0d",
                                    rx_words_seen, rx_cyc_q[0], cyc));
            end else begin
                compare_tlp128($sformatf("rx word %0d", rx_words_seen), rx_exp_q.pop_front(),
                               tlp_rx);
                void'(rx_cyc_q.pop_front());
                rx_words_seen++;
            end
        end
    end

    // --------------------
    // transmit side
    // --------------------
    task automatic run_tx_pass(bit rand_ready, string tag);
        core_tx_beat_t e;
        logic [31:0]   rnd;
        int            waited;
        int            beats_left;
        bit            done;
        for (int k = 0; k < TX_N; k++) begin
            e.data = tx_words[k].data[CORE_DATA_W-1:0];               // lower half first
            e.keep = tx_words[k].keepdw[1] ? KEEP_TWO_DW : KEEP_ONE_DW;
            e.last = tx_words[k].last && !tx_words[k].keepdw[2];
            tx_exp_q.push_back(e);
            beats_left = 1;
            if (tx_words[k].keepdw[2]) begin
                e.data = tx_words[k].data[TLP_DATA_W-1 -: CORE_DATA_W];
                e.keep = tx_words[k].keepdw[3] ? KEEP_TWO_DW : KEEP_ONE_DW;
                e.last = tx_words[k].last;
                tx_exp_q.push_back(e);
                beats_left = 2;
            end
            waited = 0;
            done   = 1'b0;
            while (!done) begin
                if (waited == TIMEOUT) begin
                    abort_run($sformatf("timeout: o_tlp_tx_ready never took %s word %0d", tag, k));
                end else begin
                    @(negedge clk_pcie);
                    rnd           = $random(seed);
                    tlp_tx        = tx_words[k];
                    tlp_tx_valid  = 1'b1;
                    core_tx_ready = rand_ready ? rnd[0] : 1'b1;
                    #1;
                    if (core_tx_valid !== 1'b1) begin
                        abort_run($sformatf("Mismatch %s word %0d core valid: expected 1 actual %b",
                                            tag, k, core_tx_valid));
                    end else if (core_tx_ready) begin
                        if (tx_exp_q.size() == 0) begin
                            abort_run($sformatf("%s word %0d sent an extra core beat", tag, k));
                        end else begin
                            compare_core_tx($sformatf("%s word %0d beat", tag, k),
                                            tx_exp_q.pop_front(), core_tx);
                            beats_left--;
                        end
                    end
                    if (tlp_tx_ready) begin
                        if (beats_left != 0) begin
                            abort_run($sformatf("o_tlp_tx_ready high before %s word %0d finished",
                                                tag, k));
                        end else begin
                            done = 1'b1;                      // word taken exactly once
                            tx_words_done++;
                        end
                    end
                    waited++;
                end
            end
        end
        @(negedge clk_pcie);
        tlp_tx_valid  = 1'b0;
        core_tx_ready = 1'b1;
        #1;
        if (core_tx_valid !== 1'b0) begin
            abort_run($sformatf("Mismatch %s idle core valid: expected 0 actual %b",
                                tag, core_tx_valid));
        end
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        rst           = 1'b1;
        core_rx       = '0;
        core_rx_valid = 1'b0;
        tlp_tx        = '0;
        tlp_tx_valid  = 1'b0;
        core_tx_ready = 1'b1;
        for (int i = 0; i < RX_N; i++) begin
            for (int j = 0; j <= MAX_DW; j++) begin
                rx_payload[i][j] = $random(seed);
            end
        end
        for (int k = 0; k < TX_N; k++) begin
            tx_words[k] = '0;
            for (int j = 0; j < TLP_DW_N; j++) begin
                tx_words[k].data[32*j +: 32] = $random(seed);
            end
            tx_words[k].keepdw = tx_table[k].keepdw;
            tx_words[k].last   = tx_table[k].last;
        end
        apply_reset();

        // rx packing with the table gaps, then the same tlps back to back
        for (int i = 0; i < RX_N; i++) begin
            send_rx_tlp(i, rx_table[i].gaps, MAX_DW);
        end
        drive_rx_idle();
        wait_rx_drained();
        for (int i = 0; i < RX_N; i++) begin
            send_rx_tlp(i, 1'b0, MAX_DW);
        end
        drive_rx_idle();
        wait_rx_drained();

        run_tx_pass(1'b0, "tx ready");
        run_tx_pass(1'b1, "tx backpressure");

        // 8 dw tlp cut after 4 dws, reset lands while its first word is on the output
        send_rx_tlp(4, 1'b0, 4);
        apply_reset();
        rx_words_pushed = rx_words_pushed - rx_exp_q.size();   // word swallowed by reset
        rx_exp_q.delete();
        rx_cyc_q.delete();
        check_rx_quiet();
        send_rx_tlp(2, 1'b0, MAX_DW);        // must open with first set
        drive_rx_idle();
        wait_rx_drained();

        if (rx_words_seen == rx_words_pushed && tx_words_done == 2 * TX_N
                && tx_exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("word counts off: rx %0d of %0d, tx %0d of %0d",
                     rx_words_seen, rx_words_pushed, tx_words_done, 2 * TX_N);
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

/* pcie_tlp_bridge.f */
logic/pcie_stream_pkg.sv
logic/tlp_rx_upsizer.sv
logic/tlp_tx_downsizer.sv
logic/pcie_tlp_bridge.sv
testbench/tb_pcie_tlp_bridge.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pcie_tlp_bridge
FILELIST  = pcie_tlp_bridge.f

OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
